// ==== gpc_dmem.f ====
design/gpc_mem_map_pkg.sv
design/gpc_access_pkg.sv
design/mem_access_if.sv
design/d_mem.sv
design/mmio_general.sv
design/dmem_region_mux.sv
design/gpc_dmem_top.sv
bench/clk_rst_gen.sv
bench/gpc_dmem_asserts.sv
bench/gpc_dmem_tb.sv

// ==== Bender.yml ====
package:
  name: gpc_dmem

sources:
  # Design, packages first
  - design/gpc_mem_map_pkg.sv
  - design/gpc_access_pkg.sv
  - design/mem_access_if.sv
  - design/d_mem.sv
  - design/mmio_general.sv
  - design/dmem_region_mux.sv
  - design/gpc_dmem_top.sv

  # Testbench
  - target: test
    files:
      - bench/clk_rst_gen.sv
      - bench/gpc_dmem_asserts.sv
      - bench/gpc_dmem_tb.sv

// ==== bench/gpc_dmem_tb.sv ====
`timescale 1ns/1ps

module gpc_dmem_tb;

    logic                        clock;
    logic                        arst_n;
    gpc_mem_map_pkg::core_addr_t address;
    gpc_access_pkg::byte_en_t    byteena;
    gpc_access_pkg::mem_word_t   data;
    logic                        rden;
    logic                        wren;
    gpc_access_pkg::mem_word_t   q;

    // Shadow of the whole decoded space, 0 to 0xF9F
    gpc_access_pkg::mem_byte_t shadow [32'h0FA0];
    bit                        known  [32'h0FA0];

    // Reads in flight, oldest first
    gpc_access_pkg::mem_word_t    exp_words   [$];
    bit                           exp_known   [$];
    gpc_mem_map_pkg::mem_region_e exp_regions [$];

    // Read sampled at the last edge
    bit     pending_check = 1'b0;
    integer seed;

    clk_rst_gen u_clk_rst (.clock(clock), .arst_n(arst_n));

    gpc_dmem_top uut (
        .clock(clock), .arst_n(arst_n), .address(address), .byteena(byteena),
        .data(data), .rden(rden), .wren(wren), .q(q)
    );

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Region bounds 0xD00, 0xF00, 0xFA0
    function automatic gpc_mem_map_pkg::mem_region_e expected_region(
        gpc_mem_map_pkg::core_addr_t addr);
        gpc_mem_map_pkg::core_addr_t aligned;
        aligned = {addr[31:2], 2'b00};
        if (aligned < 32'h0000_0D00) return gpc_mem_map_pkg::REGION_DATA;
        if (aligned < 32'h0000_0F00) return gpc_mem_map_pkg::REGION_STACK;
        if (aligned < 32'h0000_0FA0) return gpc_mem_map_pkg::REGION_MMIO;
        return gpc_mem_map_pkg::REGION_NONE;
    endfunction

    // Little endian word, zero when out of range
    function automatic gpc_access_pkg::mem_word_t expected_word(
        gpc_mem_map_pkg::core_addr_t addr);
        gpc_mem_map_pkg::core_addr_t aligned;
        gpc_access_pkg::mem_word_t   w;
        aligned = {addr[31:2], 2'b00};
        w = '0;
        if (aligned < 32'h0000_0FA0) begin
            for (int k = 0; k < 4; k++) begin
                w[k*8 +: 8] = shadow[aligned + k];
            end
        end
        return w;
    endfunction

    // False if any byte never written
    function automatic bit word_known(gpc_mem_map_pkg::core_addr_t addr);
        gpc_mem_map_pkg::core_addr_t aligned;
        aligned = {addr[31:2], 2'b00};
        if (aligned >= 32'h0000_0FA0) return 1'b1;
        return known[aligned] && known[aligned + 1] && known[aligned + 2] && known[aligned + 3];
    endfunction

    // Fill value mixes every address bit
    function automatic gpc_access_pkg::mem_word_t fill_word(gpc_mem_map_pkg::core_addr_t addr);
        return {addr[15:0] ^ addr[31:16] ^ 16'hA5C3, ~addr[15:0]};
    endfunction

    // ----------------------------------------
    // Failure and compare tasks
    // ----------------------------------------

    task automatic abort_run(string why);
        $display("TB FAILED");
        $fatal(1, why);
    endtask

    task automatic check_word(string name, gpc_access_pkg::mem_word_t actual,
                              gpc_access_pkg::mem_word_t expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
            abort_run("read data differs from the reference model");
        end
    endtask

    task automatic check_region(string name, gpc_mem_map_pkg::mem_region_e actual,
                                gpc_mem_map_pkg::mem_region_e expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s got %s expected %s", $time, name,
                     actual.name(), expected.name());
            abort_run("read region differs from the reference model");
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    // One access, old contents queued before the write lands
    task automatic drive_cycle(gpc_mem_map_pkg::core_addr_t addr,
                               gpc_access_pkg::byte_en_t be,
                               gpc_access_pkg::mem_word_t wdata, bit rd, bit wr);
        gpc_mem_map_pkg::core_addr_t aligned;
        @(posedge clock);
        #2;
        address = addr;
        byteena = be;
        data    = wdata;
        rden    = rd;
        wren    = wr;
        aligned = {addr[31:2], 2'b00};
        if (rd) begin
            exp_words.push_back(expected_word(addr));
            exp_known.push_back(word_known(addr));
            exp_regions.push_back(expected_region(addr));
        end
        if (wr && aligned < 32'h0000_0FA0) begin
            for (int k = 0; k < 4; k++) begin
                if (be[k]) begin
                    shadow[aligned + k] = wdata[k*8 +: 8];
                    known[aligned + k]  = 1'b1;
                end
            end
        end
    endtask

    task automatic idle_cycle();
        @(posedge clock);
        #2;
        rden = 1'b0;
        wren = 1'b0;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clock);
            cycles++;
            if (cycles > 10) abort_run("reset was never released");
        end
    endtask

    // Strobes dropped first so no extra read is issued
    task automatic wait_reads_done();
        int cycles;
        cycles = 0;
        idle_cycle();
        while (exp_words.size() != 0 || pending_check) begin
            @(posedge clock);
            cycles++;
            if (cycles > 20) abort_run("read results did not arrive in time");
        end
    endtask

    // ----------------------------------------
    // Compare process, mid cycle where q is stable
    // ----------------------------------------

    always @(negedge clock) begin : compare_reads
        gpc_access_pkg::mem_word_t    want;
        bit                           want_known;
        gpc_mem_map_pkg::mem_region_e want_region;
        if (pending_check) begin
            if (exp_words.size() == 0) begin
                abort_run("a read result arrived with no read outstanding");
            end
            want        = exp_words.pop_front();
            want_known  = exp_known.pop_front();
            want_region = exp_regions.pop_front();
            check_region("rd_region", uut.u_region_mux.rd_region, want_region);
            if (want_known) check_word("q", q, want);
        end
        if (uut.u_region_mux.u_asserts.fail_count != 0) begin
            abort_run("a concurrent assertion failed in the region mux");
        end
        // Strobe driven now is sampled at the next edge
        pending_check = rden && arst_n;
    end

    initial begin
        gpc_mem_map_pkg::core_addr_t edges [6];
        gpc_mem_map_pkg::core_addr_t addr;
        int                          sel;
        address = '0;
        byteena = '0;
        data    = '0;
        rden    = 1'b0;
        wren    = 1'b0;
        seed    = 32'h03cd_8712;
        edges   = '{32'h000, 32'hCFC, 32'hD00, 32'hEFC, 32'hF00, 32'hF9C};
        // MMIO resets to zero, the array does not
        for (int i = 0; i < 32'h0FA0; i++) begin
            shadow[i] = '0;
            known[i]  = (i >= 32'h0F00);
        end

        // Reset state
        wait_reset_release();
        @(negedge clock);
        check_word("q", q, '0);
        drive_cycle(32'hF00, '0, '0, 1'b1, 1'b0);
        drive_cycle(32'hF50, '0, '0, 1'b1, 1'b0);
        drive_cycle(32'hF9C, '0, '0, 1'b1, 1'b0);
        wait_reads_done();

        // Full words at the region edges
        foreach (edges[i]) drive_cycle(edges[i], 4'hF, fill_word(edges[i]), 1'b0, 1'b1);
        foreach (edges[i]) drive_cycle(edges[i], '0, '0, 1'b1, 1'b0);
        wait_reads_done();

        // Partial lanes, low address bits ignored
        drive_cycle(32'hCFC, 4'b0101, 32'h1122_3344, 1'b0, 1'b1);
        drive_cycle(32'hD01, 4'b1000, 32'hAABB_CCDD, 1'b0, 1'b1);
        drive_cycle(32'hF03, 4'b0110, 32'h5566_7788, 1'b0, 1'b1);
        foreach (edges[i]) drive_cycle(edges[i], '0, '0, 1'b1, 1'b0);
        wait_reads_done();

        // Out of range writes, 0x1D00 would alias the stack if not dropped
        drive_cycle(32'h0000_0FA0, 4'hF, 32'hDEAD_BEEF, 1'b0, 1'b1);
        drive_cycle(32'h0000_1000, 4'hF, 32'hDEAD_BEEF, 1'b0, 1'b1);
        drive_cycle(32'h0000_1D00, 4'hF, 32'hDEAD_BEEF, 1'b0, 1'b1);
        drive_cycle(32'hFFFF_FF00, 4'hF, 32'hDEAD_BEEF, 1'b0, 1'b1);
        drive_cycle(32'h0000_0FA0, '0, '0, 1'b1, 1'b0);
        drive_cycle(32'h0000_1D00, '0, '0, 1'b1, 1'b0);
        foreach (edges[i]) drive_cycle(edges[i], '0, '0, 1'b1, 1'b0);
        wait_reads_done();

        // Back to back reads across regions, then read with write to one word
        drive_cycle(32'h000, '0, '0, 1'b1, 1'b0);
        drive_cycle(32'hF00, '0, '0, 1'b1, 1'b0);
        drive_cycle(32'hD00, '0, '0, 1'b1, 1'b0);
        drive_cycle(32'hFA0, '0, '0, 1'b1, 1'b0);
        drive_cycle(32'hEFC, '0, '0, 1'b1, 1'b0);
        drive_cycle(32'hD00, 4'hF, 32'h0BAD_F00D, 1'b1, 1'b1);
        drive_cycle(32'hD00, '0, '0, 1'b1, 1'b0);
        drive_cycle(32'hF9C, 4'hF, 32'hCAFE_0001, 1'b1, 1'b1);
        drive_cycle(32'hF9C, '0, '0, 1'b1, 1'b0);
        wait_reads_done();

        // Known windows for the random run
        for (int i = 0; i < 16; i++) begin
            drive_cycle(32'h100 + i * 4, 4'hF, fill_word(32'h100 + i * 4), 1'b0, 1'b1);
            drive_cycle(32'hE00 + i * 4, 4'hF, fill_word(32'hE00 + i * 4), 1'b0, 1'b1);
        end
        for (int n = 0; n < 400; n++) begin
            sel = $unsigned($random(seed)) % 4;
            case (sel)
                0:       addr = 32'h100 + ($unsigned($random(seed)) % 16) * 4;
                1:       addr = 32'hE00 + ($unsigned($random(seed)) % 16) * 4;
                2:       addr = 32'hF00 + ($unsigned($random(seed)) % 40) * 4;
                default: addr = 32'hFA0 + ($unsigned($random(seed)) % 64) * 4;
            endcase
            addr[1:0] = $random(seed);
            drive_cycle(addr, gpc_access_pkg::byte_en_t'($random(seed)), $random(seed),
                        $random(seed), $random(seed));
        end
        wait_reads_done();

        if (uut.u_region_mux.u_asserts.fail_count != 0) begin
            abort_run("a concurrent assertion failed during the run");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// ==== bench/gpc_dmem_asserts.sv ====
`timescale 1ns/1ps

module gpc_dmem_asserts (
    input logic                         clock,
    input logic                         arst_n,
    input logic                         rden,
    input gpc_mem_map_pkg::core_addr_t  address,
    input gpc_access_pkg::mem_word_t    q,
    input logic                         mem_rden,
    input logic                         mem_wren,
    input logic                         mmio_rden,
    input logic                         mmio_wren
);

    // Failed assertion count, read by the testbench
    int fail_count = 0;

    // Port address with the low bits dropped
    gpc_mem_map_pkg::core_addr_t addr_aligned;

    assign addr_aligned = {address[31:2], 2'b00};

    // ----------------------------------------
    // Strobe steering
    // ----------------------------------------

    // Each store strobed only inside its own range, so never both at once
    one_store_a: assert property (@(posedge clock) disable iff (!arst_n)
        !((mem_rden || mem_wren) &&
          addr_aligned >= gpc_mem_map_pkg::OFFSET_MMIO_GENERAL) &&
        !((mmio_rden || mmio_wren) &&
          (addr_aligned < gpc_mem_map_pkg::OFFSET_MMIO_GENERAL ||
           addr_aligned >= gpc_mem_map_pkg::LOCAL_MEM_SIZE)))
        else begin
            fail_count++;
            $error("store strobed outside its address range");
        end

    // ----------------------------------------
    // Read return
    // ----------------------------------------

    // Out of range read gives zero next cycle
    none_zero_a: assert property (@(posedge clock) disable iff (!arst_n)
        (rden && addr_aligned >= gpc_mem_map_pkg::LOCAL_MEM_SIZE) |=> (q == '0))
        else begin
            fail_count++;
            $error("out of range read returned nonzero data");
        end

    // Result holds while no read
    q_hold_a: assert property (@(posedge clock) disable iff (!arst_n)
        !rden |=> $stable(q))
        else begin
            fail_count++;
            $error("read result changed with no read");
        end

endmodule

bind dmem_region_mux gpc_dmem_asserts u_asserts (
    .clock     (clock),
    .arst_n    (arst_n),
    .rden      (rden),
    .address   (address),
    .q         (q),
    .mem_rden  (mem_bus.rden),
    .mem_wren  (mem_bus.wren),
    .mmio_rden (mmio_bus.rden),
    .mmio_wren (mmio_bus.wren)
);

// ==== bench/clk_rst_gen.sv ====
`timescale 1ns/1ps

module clk_rst_gen (
    output logic clock,
    output logic arst_n
);

    // 40 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    // Reset held over 4 rising edges, released just after the last
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clock);
        #2 arst_n = 1'b1;
    end

endmodule

// ==== design/gpc_dmem_top.sv ====
`timescale 1ns/1ps

module gpc_dmem_top (
    input  logic                        clock,
    input  logic                        arst_n,
    input  gpc_mem_map_pkg::core_addr_t address,
    input  gpc_access_pkg::byte_en_t    byteena,
    input  gpc_access_pkg::mem_word_t   data,
    input  logic                        rden,
    input  logic                        wren,
    output gpc_access_pkg::mem_word_t   q
);

    // ----------------------------------------
    // Store buses
    // ----------------------------------------

    // Data and stack array
    mem_access_if mem_bus ();

    // General MMIO registers
    mem_access_if mmio_bus ();

    // ----------------------------------------
    // Decode and return mux
    // ----------------------------------------

    dmem_region_mux u_region_mux (
        .clock    (clock),
        .arst_n   (arst_n),
        .address  (address),
        .byteena  (byteena),
        .data     (data),
        .rden     (rden),
        .wren     (wren),
        .q        (q),
        .mem_bus  (mem_bus.ctrl),
        .mmio_bus (mmio_bus.ctrl)
    );

    // ----------------------------------------
    // Stores
    // ----------------------------------------

    d_mem u_d_mem (
        .clock  (clock),
        .arst_n (arst_n),
        .bus    (mem_bus.store)
    );

    mmio_general u_mmio_general (
        .clock  (clock),
        .arst_n (arst_n),
        .bus    (mmio_bus.store)
    );

endmodule

// ==== design/dmem_region_mux.sv ====
`timescale 1ns/1ps

module dmem_region_mux (
    input  logic                        clock,
    input  logic                        arst_n,
    input  gpc_mem_map_pkg::core_addr_t address,
    input  gpc_access_pkg::byte_en_t    byteena,
    input  gpc_access_pkg::mem_word_t   data,
    input  logic                        rden,
    input  logic                        wren,
    output gpc_access_pkg::mem_word_t   q,
    mem_access_if.ctrl                  mem_bus,
    mem_access_if.ctrl                  mmio_bus
);

    // ----------------------------------------
    // Address decode
    // ----------------------------------------

    // Low two bits forced to zero
    gpc_mem_map_pkg::core_addr_t addr_aligned;

    // Offset from the MMIO base
    gpc_mem_map_pkg::core_addr_t mmio_offset;

    // Region of the current access
    gpc_mem_map_pkg::mem_region_e region;

    // Region of the read in flight
    gpc_mem_map_pkg::mem_region_e rd_region;

    // Array owns both data and stack
    logic hit_mem;
    logic hit_mmio;

    assign addr_aligned = {address[31:2], 2'b00};
    assign mmio_offset  = addr_aligned - gpc_mem_map_pkg::OFFSET_MMIO_GENERAL;

    always_comb begin
        if (addr_aligned < gpc_mem_map_pkg::OFFSET_STACK) begin
            region = gpc_mem_map_pkg::REGION_DATA;
        end else if (addr_aligned < gpc_mem_map_pkg::OFFSET_MMIO_GENERAL) begin
            region = gpc_mem_map_pkg::REGION_STACK;
        end else if (addr_aligned < gpc_mem_map_pkg::LOCAL_MEM_SIZE) begin
            region = gpc_mem_map_pkg::REGION_MMIO;
        end else begin
            region = gpc_mem_map_pkg::REGION_NONE;
        end
    end

    assign hit_mem  = (region == gpc_mem_map_pkg::REGION_DATA) ||
                      (region == gpc_mem_map_pkg::REGION_STACK);
    assign hit_mmio = (region == gpc_mem_map_pkg::REGION_MMIO);

    // ----------------------------------------
    // Request steering
    // ----------------------------------------

    // Array index is the aligned address itself
    assign mem_bus.index   = gpc_mem_map_pkg::mem_index_t'(addr_aligned);
    assign mem_bus.byteena = byteena;
    assign mem_bus.data    = data;
    assign mem_bus.rden    = rden && hit_mem;
    assign mem_bus.wren    = wren && hit_mem;

    // MMIO store sees the offset within its block
    assign mmio_bus.index   = gpc_mem_map_pkg::mem_index_t'(mmio_offset);
    assign mmio_bus.byteena = byteena;
    assign mmio_bus.data    = data;
    assign mmio_bus.rden    = rden && hit_mmio;
    assign mmio_bus.wren    = wren && hit_mmio;

    // ----------------------------------------
    // Read return
    // ----------------------------------------

    // Tracks which store answers, one read per cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_region <= gpc_mem_map_pkg::REGION_NONE;
        end else if (rden) begin
            rd_region <= region;
        end
    end

    // Out of range reads give zero
    always_comb begin
        unique case (rd_region)
            gpc_mem_map_pkg::REGION_DATA,
            gpc_mem_map_pkg::REGION_STACK: q = mem_bus.q;
            gpc_mem_map_pkg::REGION_MMIO:  q = mmio_bus.q;
            gpc_mem_map_pkg::REGION_NONE:  q = '0;
        endcase
    end

endmodule

// ==== design/mmio_general.sv ====
`timescale 1ns/1ps

module mmio_general (
    input  logic         clock,
    input  logic         arst_n,
    mem_access_if.store  bus
);

    // ----------------------------------------
    // Register block
    // ----------------------------------------

    // One register per MMIO byte
    gpc_access_pkg::mem_byte_t regs [gpc_mem_map_pkg::SIZE_MMIO_GENERAL];

    // Offset inside the block
    gpc_mem_map_pkg::mmio_index_t base_index;

    // Word seen at the current offset
    gpc_access_pkg::mem_word_t rd_word;

    // Upper index bits are zero for any MMIO hit
    assign base_index = gpc_mem_map_pkg::mmio_index_t'(bus.index);

    // ----------------------------------------
    // Write path
    // ----------------------------------------

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (bus.wren) begin
            for (int k = 0; k < gpc_access_pkg::NUM_LANES; k++) begin
                if (bus.byteena[k]) begin
                    regs[base_index + gpc_mem_map_pkg::mmio_index_t'(k)] <=
                        bus.data[k*gpc_access_pkg::BYTE_WIDTH +: gpc_access_pkg::BYTE_WIDTH];
                end
            end
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------

    // Same lane order as the data array
    always_comb begin
        for (int k = 0; k < gpc_access_pkg::NUM_LANES; k++) begin
            rd_word[k*gpc_access_pkg::BYTE_WIDTH +: gpc_access_pkg::BYTE_WIDTH] =
                regs[base_index + gpc_mem_map_pkg::mmio_index_t'(k)];
        end
    end

    // Holds between reads
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bus.q <= '0;
        end else if (bus.rden) begin
            bus.q <= rd_word;
        end
    end

endmodule

// ==== design/d_mem.sv ====
`timescale 1ns/1ps

module d_mem (
    input  logic         clock,
    input  logic         arst_n,
    mem_access_if.store  bus
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // Data region followed by the stack
    gpc_access_pkg::mem_byte_t mem [
        gpc_mem_map_pkg::LOCAL_MEM_SIZE - gpc_mem_map_pkg::SIZE_MMIO_GENERAL
    ];

    // Per lane byte address
    gpc_mem_map_pkg::mem_index_t lane_index [gpc_access_pkg::NUM_LANES];

    // Word seen at the current index
    gpc_access_pkg::mem_word_t rd_word;

    always_comb begin
        for (int k = 0; k < gpc_access_pkg::NUM_LANES; k++) begin
            lane_index[k] = bus.index + gpc_mem_map_pkg::mem_index_t'(k);
        end
    end

    // ----------------------------------------
    // Write path
    // ----------------------------------------

    // Only enabled lanes update
    always_ff @(posedge clock) begin
        if (bus.wren) begin
            for (int k = 0; k < gpc_access_pkg::NUM_LANES; k++) begin
                if (bus.byteena[k]) begin
                    mem[lane_index[k]] <=
                        bus.data[k*gpc_access_pkg::BYTE_WIDTH +: gpc_access_pkg::BYTE_WIDTH];
                end
            end
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------

    // Little endian assembly, lane 0 lowest
    always_comb begin
        for (int k = 0; k < gpc_access_pkg::NUM_LANES; k++) begin
            rd_word[k*gpc_access_pkg::BYTE_WIDTH +: gpc_access_pkg::BYTE_WIDTH] =
                mem[lane_index[k]];
        end
    end

    // Sampled before the write lands, so a colliding write is not seen
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bus.q <= '0;
        end else if (bus.rden) begin
            bus.q <= rd_word;
        end
    end

endmodule

// ==== design/mem_access_if.sv ====
`timescale 1ns/1ps

interface mem_access_if;

    // ----------------------------------------
    // Request side
    // ----------------------------------------

    // Byte index of lane 0, word aligned
    gpc_mem_map_pkg::mem_index_t index;
    gpc_access_pkg::byte_en_t    byteena;
    gpc_access_pkg::mem_word_t   data;

    // Single cycle strobes
    logic rden;
    logic wren;

    // ----------------------------------------
    // Response side
    // ----------------------------------------

    // Registered read word from the store
    gpc_access_pkg::mem_word_t q;

    // Decoder end
    modport ctrl (
        output index, byteena, data, rden, wren,
        input  q
    );

    // Storage end
    modport store (
        input  index, byteena, data, rden, wren,
        output q
    );

endinterface

// ==== design/gpc_access_pkg.sv ====
package gpc_access_pkg;

    // ----------------------------------------
    // Lane geometry
    // ----------------------------------------

    // Byte lanes per core word
    localparam int NUM_LANES = 4;

    // Bits per lane
    localparam int BYTE_WIDTH = 8;

    // ----------------------------------------
    // Data types
    // ----------------------------------------

    // One stored byte
    typedef logic [BYTE_WIDTH-1:0] mem_byte_t;

    // Full core word, lane 0 in the low byte
    typedef logic [NUM_LANES*BYTE_WIDTH-1:0] mem_word_t;

    // One enable bit per lane
    typedef logic [NUM_LANES-1:0] byte_en_t;

endpackage

// ==== design/gpc_mem_map_pkg.sv ====
package gpc_mem_map_pkg;

    // ----------------------------------------
    // Address types
    // ----------------------------------------

    // Core byte address as seen on the port
    typedef logic [31:0] core_addr_t;

    // Byte index into the data and stack array
    typedef logic [11:0] mem_index_t;

    // Byte index inside the MMIO block
    typedef logic [7:0] mmio_index_t;

    // Region hit by one access
    typedef enum logic [1:0] {
        REGION_DATA  = 2'd0,
        REGION_STACK = 2'd1,
        REGION_MMIO  = 2'd2,
        REGION_NONE  = 2'd3
    } mem_region_e;

    // ----------------------------------------
    // Region sizes and bases
    // ----------------------------------------

    localparam core_addr_t SIZE_DATA         = 32'h0000_0D00;
    localparam core_addr_t SIZE_STACK        = 32'h0000_0200;
    localparam core_addr_t SIZE_MMIO_GENERAL = 32'h0000_00A0;

    // Regions are packed back to back from zero
    localparam core_addr_t OFFSET_STACK        = SIZE_DATA;
    localparam core_addr_t OFFSET_MMIO_GENERAL = SIZE_DATA + SIZE_STACK;

    // First byte past the decoded space
    localparam core_addr_t LOCAL_MEM_SIZE = SIZE_DATA + SIZE_STACK + SIZE_MMIO_GENERAL;

endpackage
